/* rtl/iter_control.sv */
// Sample iterator control FSM
`timescale 1ns/1ps
`default_nettype none

module iter_control #(
    parameter int SIGFIG = raster_pkg::SIGFIG_DEF,
    parameter int RADIX  = raster_pkg::RADIX_DEF
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     tri_valid,
    input  wire logic                     front,     // Cull verdict
    input  wire logic                     at_end,    // Last quad showing
    input  wire logic signed [SIGFIG-1:0] tri_x_in [raster_pkg::VERTS],
    input  wire logic signed [SIGFIG-1:0] tri_y_in [raster_pkg::VERTS],
    input  wire logic signed [SIGFIG-1:0] tri_z_in [raster_pkg::VERTS],
    input  wire logic        [SIGFIG-1:0] color_in [raster_pkg::COLORS],
    output logic                          hold,
    output logic                          samp_valid,
    output logic                          load,
    output logic                          advance,
    output logic signed [SIGFIG-1:0]      tri_x [raster_pkg::VERTS],
    output logic signed [SIGFIG-1:0]      tri_y [raster_pkg::VERTS],
    output logic signed [SIGFIG-1:0]      tri_z [raster_pkg::VERTS],
    output logic        [SIGFIG-1:0]      color [raster_pkg::COLORS]
);

    // 64x needs a step of an eighth of a pixel
    if (RADIX < 3) begin : g_fmt_check
        $error("iter_control: RADIX below 3 cannot express the 64x step");
    end

    raster_pkg::iter_state_t state;
    raster_pkg::iter_state_t state_nxt;

    // Latched triangle indexed by vertex then axis
    logic signed [SIGFIG-1:0] tri_q [raster_pkg::VERTS][raster_pkg::AXES];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= raster_pkg::WAIT;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            raster_pkg::WAIT: if (tri_valid) state_nxt = raster_pkg::CULL;
            raster_pkg::CULL: state_nxt = front ? raster_pkg::WALK : raster_pkg::WAIT;
            raster_pkg::WALK: if (at_end) state_nxt = raster_pkg::WAIT;
            default:          state_nxt = raster_pkg::WAIT;
        endcase
    end

    // Moore outputs
    assign hold       = (state != raster_pkg::WAIT);  // Low only while idle
    assign samp_valid = (state == raster_pkg::WALK);  // Nothing valid before the verdict
    assign load       = (state == raster_pkg::WAIT) && tri_valid;  // Acceptance
    assign advance    = (state == raster_pkg::WALK) && !at_end;

    // Triangle and colour pass through registered, held for the whole walk
    always_ff @(posedge clk) begin
        if (load) begin
            for (int v = 0; v < raster_pkg::VERTS; v++) begin
                tri_q[v][0] <= tri_x_in[v];
                tri_q[v][1] <= tri_y_in[v];
                tri_q[v][2] <= tri_z_in[v];
            end
            for (int c = 0; c < raster_pkg::COLORS; c++) begin
                color[c] <= color_in[c];
            end
        end
    end

    always_comb begin
        for (int v = 0; v < raster_pkg::VERTS; v++) begin
            tri_x[v] = tri_q[v][0];
            tri_y[v] = tri_q[v][1];
            tri_z[v] = tri_q[v][2];
        end
    end

endmodule

`default_nettype wire

/* rtl/quad_walker.sv */
// Quad walker over the bounding box
`timescale 1ns/1ps
`default_nettype none

module quad_walker #(
    parameter int SIGFIG = raster_pkg::SIGFIG_DEF,
    parameter int RADIX  = raster_pkg::RADIX_DEF
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     load,        // Capture box and start at origin
    input  wire logic                     advance,     // Step to the next quad
    input  wire raster_pkg::msaa_t        subsample,
    input  wire logic signed [SIGFIG-1:0] box_lo_x,
    input  wire logic signed [SIGFIG-1:0] box_lo_y,
    input  wire logic signed [SIGFIG-1:0] box_hi_x,
    input  wire logic signed [SIGFIG-1:0] box_hi_y,
    output logic signed [SIGFIG-1:0]      samp_x [4],
    output logic signed [SIGFIG-1:0]      samp_y [4],
    output logic                          at_end       // Quad covers the top-right corner
);

    // Sample step in fixed point
    logic signed [SIGFIG-1:0] step;
    logic signed [SIGFIG-1:0] step2;  // Quad pitch

    // Captured box edges
    // Bottom edge only matters at load time
    logic signed [SIGFIG-1:0] lo_x_q;   // Row restart column
    logic signed [SIGFIG-1:0] hi_x_q;
    logic signed [SIGFIG-1:0] hi_y_q;

    // Quad origin is the bottom-left sample
    logic signed [SIGFIG-1:0] qx;
    logic signed [SIGFIG-1:0] qy;
    logic signed [SIGFIG-1:0] rx;  // Right column
    logic signed [SIGFIG-1:0] ty;  // Top row

    logic right_col;  // Either column on the right edge
    logic top_row;    // Either row on the top edge

    // One-hot code lands on the bit for 1, 1/2, 1/4 or 1/8 pixel
    assign step  = SIGFIG'(subsample) << (RADIX - 3);
    assign step2 = step << 1;

    assign rx = qx + step;
    assign ty = qy + step;

    // Sample order is bottom-left, top-left, bottom-right, top-right
    always_comb begin
        samp_x[0] = qx;
        samp_y[0] = qy;
        samp_x[1] = qx;
        samp_y[1] = ty;
        samp_x[2] = rx;
        samp_y[2] = qy;
        samp_x[3] = rx;
        samp_y[3] = ty;
    end

    // A hit in either column wraps the whole quad
    assign right_col = (qx == hi_x_q) || (rx == hi_x_q);
    assign top_row   = (qy == hi_y_q) || (ty == hi_y_q);
    assign at_end    = right_col && top_row;

    // Box registers
    always_ff @(posedge clk) begin
        if (load) begin
            lo_x_q <= box_lo_x;
            hi_x_q <= box_hi_x;
            hi_y_q <= box_hi_y;
        end
    end

    // Walk left to right, then up one quad row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            qx <= '0;
            qy <= '0;
        end else if (load) begin
            qx <= box_lo_x;  // Start at the box origin
            qy <= box_lo_y;
        end else if (advance) begin
            if (right_col) begin
                qx <= lo_x_q;        // Back to the left edge
                qy <= qy + step2;    // Next row of quads
            end else begin
                qx <= qx + step2;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/raster_pkg.sv */
// Sample iterator shared definitions
`default_nettype none

package raster_pkg;

    // Fixed-point format defaults
    localparam int SIGFIG_DEF = 24;  // Total signed bits per coordinate or channel
    localparam int RADIX_DEF  = 10;  // Fraction bits

    // Triangle shape
    localparam int VERTS  = 3;       // Vertices per triangle
    localparam int AXES   = 3;       // Axes per vertex in x y z order
    localparam int COLORS = 3;       // Colour channels

    // Top bits dropped from each edge vector ahead of the cull multiply
    localparam int CULL_DROP = 9;

    // Iterator FSM states
    typedef enum logic [1:0] {
        WAIT = 2'd0,                 // Idle and accepting
        CULL = 2'd1,                 // Facing verdict pending
        WALK = 2'd2                  // One quad per clock
    } iter_state_t;

    // One-hot MSAA code
    // Shifted left by RADIX-3 it gives one sample step in fixed point
    typedef enum logic [3:0] {
        MSAA_1X  = 4'b1000,          // Step of one pixel
        MSAA_4X  = 4'b0100,          // Half pixel
        MSAA_16X = 4'b0010,          // Quarter pixel
        MSAA_64X = 4'b0001           // Eighth of a pixel
    } msaa_t;

endpackage

`default_nettype wire

/* rtl/sample_iterator.sv */
// Bounding-box sample iterator
`timescale 1ns/1ps
`default_nettype none

module sample_iterator #(
    parameter int SIGFIG = raster_pkg::SIGFIG_DEF,
    parameter int RADIX  = raster_pkg::RADIX_DEF
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    // Upstream triangle
    input  wire logic signed [SIGFIG-1:0] tri_x_in [raster_pkg::VERTS],
    input  wire logic signed [SIGFIG-1:0] tri_y_in [raster_pkg::VERTS],
    input  wire logic signed [SIGFIG-1:0] tri_z_in [raster_pkg::VERTS],
    input  wire logic        [SIGFIG-1:0] color_in [raster_pkg::COLORS],
    input  wire logic signed [SIGFIG-1:0] box_lo_x,  // Box on the sample grid
    input  wire logic signed [SIGFIG-1:0] box_lo_y,
    input  wire logic signed [SIGFIG-1:0] box_hi_x,
    input  wire logic signed [SIGFIG-1:0] box_hi_y,
    input  wire logic                     tri_valid,
    input  wire raster_pkg::msaa_t        subsample,  // Stable during a triangle
    // Downstream quad
    output logic signed [SIGFIG-1:0]      tri_x [raster_pkg::VERTS],
    output logic signed [SIGFIG-1:0]      tri_y [raster_pkg::VERTS],
    output logic signed [SIGFIG-1:0]      tri_z [raster_pkg::VERTS],
    output logic        [SIGFIG-1:0]      color [raster_pkg::COLORS],
    output logic signed [SIGFIG-1:0]      samp_x [4],
    output logic signed [SIGFIG-1:0]      samp_y [4],
    output logic                          samp_valid,
    output logic                          hold        // Upstream stall
);

    logic front;    // Triangle faces the viewer
    logic at_end;   // Walker on its last quad
    logic load;     // Accept and start the walk
    logic advance;  // Next quad

    // Cull and walker run side by side from the same acceptance edge
    triangle_cull #(
        .SIGFIG (SIGFIG),
        .RADIX  (RADIX)
    ) u_triangle_cull (
        .clk    (clk),
        .rst    (rst),
        .tri_x  (tri_x_in),
        .tri_y  (tri_y_in),
        .front  (front)
    );

    quad_walker #(
        .SIGFIG (SIGFIG),
        .RADIX  (RADIX)
    ) u_quad_walker (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .advance   (advance),
        .subsample (subsample),
        .box_lo_x  (box_lo_x),
        .box_lo_y  (box_lo_y),
        .box_hi_x  (box_hi_x),
        .box_hi_y  (box_hi_y),
        .samp_x    (samp_x),
        .samp_y    (samp_y),
        .at_end    (at_end)
    );

    iter_control #(
        .SIGFIG (SIGFIG),
        .RADIX  (RADIX)
    ) u_iter_control (
        .clk        (clk),
        .rst        (rst),
        .tri_valid  (tri_valid),
        .front      (front),
        .at_end     (at_end),
        .tri_x_in   (tri_x_in),
        .tri_y_in   (tri_y_in),
        .tri_z_in   (tri_z_in),
        .color_in   (color_in),
        .hold       (hold),
        .samp_valid (samp_valid),
        .load       (load),
        .advance    (advance),
        .tri_x      (tri_x),
        .tri_y      (tri_y),
        .tri_z      (tri_z),
        .color      (color)
    );

endmodule

`default_nettype wire

/* rtl/triangle_cull.sv */
// Back-face cull
`timescale 1ns/1ps
`default_nettype none

module triangle_cull #(
    parameter int SIGFIG = raster_pkg::SIGFIG_DEF,
    parameter int RADIX  = raster_pkg::RADIX_DEF
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic signed [SIGFIG-1:0] tri_x [raster_pkg::VERTS],
    input  wire logic signed [SIGFIG-1:0] tri_y [raster_pkg::VERTS],
    output logic                          front
);

    localparam int SHORT = SIGFIG - raster_pkg::CULL_DROP;  // Cull operand width

    // Truncated edges must still hold integer bits above the binary point
    if (SHORT <= RADIX) begin : g_fmt_check
        $error("triangle_cull: SIGFIG must exceed CULL_DROP plus RADIX");
    end

    // Full width edge vectors
    logic signed [SIGFIG-1:0]  e0_x;  // v1 - v0
    logic signed [SIGFIG-1:0]  e0_y;
    logic signed [SIGFIG-1:0]  e1_x;  // v2 - v1
    logic signed [SIGFIG-1:0]  e1_y;

    // Registered low bits of each edge
    logic signed [SHORT-1:0]   e0_x_q;
    logic signed [SHORT-1:0]   e0_y_q;
    logic signed [SHORT-1:0]   e1_x_q;
    logic signed [SHORT-1:0]   e1_y_q;

    // Cross-product terms
    logic signed [2*SHORT-1:0] cross_a;  // e0.x * e1.y
    logic signed [2*SHORT-1:0] cross_b;  // e0.y * e1.x

    always_comb begin
        e0_x = tri_x[1] - tri_x[0];
        e0_y = tri_y[1] - tri_y[0];
        e1_x = tri_x[2] - tri_x[1];
        e1_y = tri_y[2] - tri_y[1];
    end

    // Edges are captured every clock, so the verdict trails the vertices by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            e0_x_q <= '0;
            e0_y_q <= '0;
            e1_x_q <= '0;
            e1_y_q <= '0;
        end else begin
            e0_x_q <= e0_x[SHORT-1:0];  // High bits dropped
            e0_y_q <= e0_y[SHORT-1:0];
            e1_x_q <= e1_x[SHORT-1:0];
            e1_y_q <= e1_y[SHORT-1:0];
        end
    end

    assign cross_a = e0_x_q * e1_y_q;
    assign cross_b = e0_y_q * e1_x_q;

    // Non-positive signed area means the triangle faces the viewer
    assign front = (cross_a <= cross_b);

endmodule

`default_nettype wire

/* tests/iter_model.svh */
// Sample iterator reference model
`ifndef ITER_MODEL_SVH
`define ITER_MODEL_SVH

// Front facing when the signed area of the winding is not positive
function automatic bit faces_viewer(
    input longint x0,
    input longint y0,
    input longint x1,
    input longint y1,
    input longint x2,
    input longint y2
);
    longint ax;
    longint ay;
    longint bx;
    longint by;
    ax = x1 - x0;  // First edge
    ay = y1 - y0;
    bx = x2 - x1;  // Second edge
    by = y2 - y1;
    return (ax * by) <= (ay * bx);
endfunction

// Sample pitch in fixed point for each MSAA rate
function automatic longint sample_step(input logic [3:0] code, input int radix);
    case (code)
        4'b1000: return longint'(1) << radix;        // One sample per pixel
        4'b0100: return longint'(1) << (radix - 1);  // 2 by 2 per pixel
        4'b0010: return longint'(1) << (radix - 2);
        4'b0001: return longint'(1) << (radix - 3);  // 8 by 8 per pixel
        default: return 0;
    endcase
endfunction

// Quads along one axis of a box that is n samples long
function automatic int quads_along(input longint lo, input longint hi, input longint step);
    longint n;
    n = (hi - lo) / step;
    return int'(n / 2 + 1);
endfunction

// Bottom-left sample of quad number idx along one axis
function automatic longint quad_origin(input longint lo, input longint step, input int idx);
    return lo + 2 * longint'(idx) * step;
endfunction

`endif

/* tests/tb_sample_iterator.sv */
// Sample iterator testbench
`timescale 1ns/1ps
`default_nettype none

module tb_sample_iterator;

    localparam int SIGFIG      = raster_pkg::SIGFIG_DEF;
    localparam int RADIX       = raster_pkg::RADIX_DEF;
    localparam int CLK_PERIOD  = 4;
    localparam int DRIVE_DELAY = 1;   // Inputs change this long after the rising edge
    localparam int RST_CYCLES  = 8;
    localparam int IDLE_START  = 3;   // Quiet cycles before the first triangle
    localparam int NUM_TRI     = 200;
    localparam int MAX_SPAN    = 6;   // Box side in samples
    localparam int MAX_QUADS   = (MAX_SPAN / 2 + 1) * (MAX_SPAN / 2 + 1);
    localparam int WATCHDOG_NS =
        (NUM_TRI * (MAX_QUADS + 4) + RST_CYCLES + IDLE_START + 4) * CLK_PERIOD;

    typedef enum {MON_IDLE, MON_CULL, MON_WALK} mon_phase_t;

    logic clk;
    logic rst;
    logic signed [SIGFIG-1:0] tri_x_in [raster_pkg::VERTS];
    logic signed [SIGFIG-1:0] tri_y_in [raster_pkg::VERTS];
    logic signed [SIGFIG-1:0] tri_z_in [raster_pkg::VERTS];
    logic        [SIGFIG-1:0] color_in [raster_pkg::COLORS];
    logic signed [SIGFIG-1:0] box_lo_x;
    logic signed [SIGFIG-1:0] box_lo_y;
    logic signed [SIGFIG-1:0] box_hi_x;
    logic signed [SIGFIG-1:0] box_hi_y;
    logic                     tri_valid;
    raster_pkg::msaa_t        subsample;
    logic signed [SIGFIG-1:0] tri_x [raster_pkg::VERTS];
    logic signed [SIGFIG-1:0] tri_y [raster_pkg::VERTS];
    logic signed [SIGFIG-1:0] tri_z [raster_pkg::VERTS];
    logic        [SIGFIG-1:0] color [raster_pkg::COLORS];
    logic signed [SIGFIG-1:0] samp_x [4];
    logic signed [SIGFIG-1:0] samp_y [4];
    logic                     samp_valid;
    logic                     hold;

    // Expected state of the triangle in flight
    logic signed [SIGFIG-1:0] acc_x [raster_pkg::VERTS];
    logic signed [SIGFIG-1:0] acc_y [raster_pkg::VERTS];
    logic signed [SIGFIG-1:0] acc_z [raster_pkg::VERTS];
    logic        [SIGFIG-1:0] acc_c [raster_pkg::COLORS];
    longint     exp_ox [$];             // Quad origins in walk order
    longint     exp_oy [$];
    longint     exp_step;
    bit         exp_front;
    int         exp_quads;
    int         quads_seen;
    bit         open_test  = 1'b0;
    mon_phase_t phase      = MON_IDLE;
    integer     seed;
    int         errors     = 0;
    int         checks     = 0;
    int         tests_done = 0;
    int         err_at_start;

    `include "iter_model.svh"

    sample_iterator #(
        .SIGFIG (SIGFIG),
        .RADIX  (RADIX)
    ) u_sample_iterator (
        .clk        (clk),
        .rst        (rst),
        .tri_x_in   (tri_x_in),
        .tri_y_in   (tri_y_in),
        .tri_z_in   (tri_z_in),
        .color_in   (color_in),
        .box_lo_x   (box_lo_x),
        .box_lo_y   (box_lo_y),
        .box_hi_x   (box_hi_x),
        .box_hi_y   (box_hi_y),
        .tri_valid  (tri_valid),
        .subsample  (subsample),
        .tri_x      (tri_x),
        .tri_y      (tri_y),
        .tri_z      (tri_z),
        .color      (color),
        .samp_x     (samp_x),
        .samp_y     (samp_y),
        .samp_valid (samp_valid),
        .hold       (hold)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("MISMATCH at %0d ns: %s", $time, msg);
            errors++;
        end
    endtask

    // Random triangle, box and MSAA rate held until hold drops
    task automatic drive_triangle();
        int         gap;
        int         w;
        int         h;
        longint     s;
        logic [3:0] onehot;
        gap = $random(seed) & 1;
        if (gap != 0) begin
            tri_valid = 1'b0;  // One idle cycle
            @(posedge clk);
            #DRIVE_DELAY;
        end
        onehot    = 4'b1000 >> ($random(seed) & 3);
        subsample = raster_pkg::msaa_t'(onehot);
        s         = sample_step(onehot, RADIX);
        w         = (($random(seed) & 32'h7fff_ffff) % (MAX_SPAN + 1));
        h         = (($random(seed) & 32'h7fff_ffff) % (MAX_SPAN + 1));
        box_lo_x  = SIGFIG'(($random(seed) % 16) * s);  // On the sample grid
        box_lo_y  = SIGFIG'(($random(seed) % 16) * s);
        box_hi_x  = SIGFIG'(box_lo_x + w * s);
        box_hi_y  = SIGFIG'(box_lo_y + h * s);
        for (int v = 0; v < raster_pkg::VERTS; v++) begin
            tri_x_in[v] = SIGFIG'($random(seed) % 4096);  // Small enough that truncation never bites
            tri_y_in[v] = SIGFIG'($random(seed) % 4096);
            tri_z_in[v] = SIGFIG'($random(seed));
        end
        for (int c = 0; c < raster_pkg::COLORS; c++) begin
            color_in[c] = SIGFIG'($random(seed));
        end
        tri_valid = 1'b1;
        @(posedge clk);  // Accepted since hold was low
        #DRIVE_DELAY;
        while (hold) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        tri_valid = 1'b0;
    endtask

    // Build the expected quads of the triangle about to be accepted
    task automatic capture_expected();
        int nx;
        int ny;
        exp_step  = sample_step(subsample, RADIX);
        nx        = quads_along(box_lo_x, box_hi_x, exp_step);
        ny        = quads_along(box_lo_y, box_hi_y, exp_step);
        exp_front = faces_viewer(tri_x_in[0], tri_y_in[0], tri_x_in[1], tri_y_in[1],
                                 tri_x_in[2], tri_y_in[2]);
        exp_quads = exp_front ? nx * ny : 0;
        exp_ox.delete();
        exp_oy.delete();
        for (int r = 0; r < ny && exp_front; r++) begin  // Bottom row first
            for (int c = 0; c < nx; c++) begin
                exp_ox.push_back(quad_origin(box_lo_x, exp_step, c));
                exp_oy.push_back(quad_origin(box_lo_y, exp_step, r));
            end
        end
        acc_x        = tri_x_in;
        acc_y        = tri_y_in;
        acc_z        = tri_z_in;
        acc_c        = color_in;
        quads_seen   = 0;
        err_at_start = errors;
        open_test    = 1'b1;
    endtask

    function automatic bit same_triangle();
        bit ok;
        ok = 1'b1;
        for (int v = 0; v < raster_pkg::VERTS; v++) begin
            if (tri_x[v] !== acc_x[v] || tri_y[v] !== acc_y[v] || tri_z[v] !== acc_z[v]) begin
                ok = 1'b0;
            end
        end
        for (int c = 0; c < raster_pkg::COLORS; c++) begin
            if (color[c] !== acc_c[c]) ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic compare_quad();
        longint ox;
        longint oy;
        longint ex;
        longint ey;
        ox = exp_ox.pop_front();
        oy = exp_oy.pop_front();
        for (int k = 0; k < 4; k++) begin
            ex = ox + ((k >= 2) ? exp_step : 0);      // Right column
            ey = oy + ((k % 2 == 1) ? exp_step : 0);  // Top row
            check(samp_x[k] == ex && samp_y[k] == ey,
                  $sformatf("quad %0d sample %0d got (%0d,%0d) expected (%0d,%0d)",
                            quads_seen, k, samp_x[k], samp_y[k], ex, ey));
        end
        check(same_triangle(), "triangle or colour output differs from the accepted one");
        quads_seen++;
    endtask

    task automatic finish_test();
        tests_done++;
        open_test = 1'b0;
        $display("triangle %0d %s quads %0d of %0d %s", tests_done,
                 exp_front ? "front" : "back", quads_seen, exp_quads,
                 (errors == err_at_start) ? "ok" : "failed");
    endtask

    // Monitor samples mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            case (phase)
                MON_IDLE: begin
                    check(!hold && !samp_valid, "hold or samp_valid high while idle");
                    if (open_test) finish_test();  // Hold has dropped for the last one
                    if (tri_valid) begin
                        capture_expected();
                        phase = MON_CULL;
                    end
                end
                MON_CULL: begin
                    check(hold && !samp_valid, "cull cycle needs hold high and no quad");
                    phase = exp_front ? MON_WALK : MON_IDLE;
                end
                MON_WALK: begin
                    check(hold && samp_valid, "hold or samp_valid low during the walk");
                    compare_quad();
                    if (exp_ox.size() == 0) phase = MON_IDLE;
                end
                default: phase = MON_IDLE;
            endcase
        end
    end

    initial begin
        seed      = 83;
        rst       = 1'b1;
        tri_valid = 1'b0;
        subsample = raster_pkg::MSAA_1X;
        box_lo_x  = '0;
        box_lo_y  = '0;
        box_hi_x  = '0;
        box_hi_y  = '0;
        for (int v = 0; v < raster_pkg::VERTS; v++) begin
            tri_x_in[v] = '0;
            tri_y_in[v] = '0;
            tri_z_in[v] = '0;
        end
        for (int c = 0; c < raster_pkg::COLORS; c++) begin
            color_in[c] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        repeat (IDLE_START) begin  // Outputs must stay quiet before any acceptance
            @(posedge clk);
            #DRIVE_DELAY;
        end
        for (int i = 0; i < NUM_TRI; i++) begin
            drive_triangle();
        end
        wait (tests_done == NUM_TRI);
        repeat (2) @(posedge clk);
        $display("tests %0d  checks %0d  errors %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized for the longest possible walk of every triangle
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish all %0d triangles in time", NUM_TRI);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/raster_pkg.sv
rtl/triangle_cull.sv
rtl/quad_walker.sv
rtl/iter_control.sv
rtl/sample_iterator.sv
+incdir+tests
tests/tb_sample_iterator.sv
